//--- Bender.yml
package:
  name: cpu

sources:
  - common/cpu_pkg.sv
  - design/instr_decoder.sv
  - design/controller.sv
  - datapath/regfile.sv
  - datapath/datapath.sv
  - design/cpu.sv
  - target: simulation
    files:
      - verif/tb_cpu.sv

//--- common/cpu_pkg.sv
package cpu_pkg;

    localparam int word_w    = 16;
    localparam int reg_cnt   = 8;
    localparam int reg_num_w = 3;

    // instruction classes, taken from bits 15:13 of the instruction word.
    typedef enum logic [2:0] {
        op_alu = 3'b101,
        op_mov = 3'b110
    } opcode_t;

    // op field, bits 12:11, for the alu class.
    typedef enum logic [1:0] {
        alu_add = 2'b00,
        alu_cmp = 2'b01,
        alu_and = 2'b10,
        alu_mvn = 2'b11
    } alu_op_t;

    // in the move class the op field picks the source of the move.
    localparam logic [1:0] mov_imm = 2'd2;
    localparam logic [1:0] mov_reg = 2'd0;

    typedef enum logic [1:0] {
        sh_none = 2'b00,
        sh_lsl  = 2'b01,
        sh_lsr  = 2'b10,
        sh_asr  = 2'b11
    } shift_t;

    typedef enum logic [1:0] {
        sel_rm = 2'b00,
        sel_rd = 2'b01,
        sel_rn = 2'b10
    } nsel_t;

    typedef enum logic [1:0] {
        wb_c   = 2'b00,
        wb_imm = 2'b10
    } wb_sel_t;

    typedef struct packed {
        opcode_t             opcode;
        alu_op_t             op;
        shift_t              shift;
        logic [word_w-1:0]   sximm8;
    } decoded_t;

    typedef struct packed {
        logic    en_a;
        logic    en_b;
        logic    en_c;
        logic    en_status;
        logic    sel_a;     // forces the a operand to zero.
        logic    w_en;
        nsel_t   nsel;
        wb_sel_t wb_sel;
    } ctrl_t;

    typedef struct packed {
        logic z;
        logic n;
        logic v;
    } status_t;

endpackage

//--- datapath/datapath.sv
module datapath (
    input  logic                        clk,
    input  logic                        rst_n,
    input  cpu_pkg::ctrl_t              ctrl,
    input  cpu_pkg::decoded_t           dec,
    input  logic [cpu_pkg::word_w-1:0]  rd_data,
    output logic [cpu_pkg::word_w-1:0]  wr_data,
    output logic [cpu_pkg::word_w-1:0]  out,
    output cpu_pkg::status_t            status
);
    import cpu_pkg::*;

    logic [word_w-1:0] a;
    logic [word_w-1:0] b;
    logic [word_w-1:0] c;
    logic [word_w-1:0] ain;
    logic [word_w-1:0] bsh;
    logic [word_w-1:0] alu_out;
    status_t           flags;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            a <= '0;
            b <= '0;
        end else begin
            if (ctrl.en_a) begin
                a <= rd_data;
            end
            if (ctrl.en_b) begin
                b <= rd_data;
            end
        end
    end

    always_comb begin
        case (dec.shift)
            sh_lsl:  bsh = {b[word_w-2:0], 1'b0};
            sh_lsr:  bsh = {1'b0, b[word_w-1:1]};
            sh_asr:  bsh = {b[word_w-1], b[word_w-1:1]};
            default: bsh = b;
        endcase
    end

    assign ain = ctrl.sel_a ? '0 : a; // moves add shifted b to zero.

    always_comb begin
        case (dec.op)
            alu_add: alu_out = ain + bsh;
            alu_cmp: alu_out = ain - bsh;
            alu_and: alu_out = ain & bsh;
            default: alu_out = ~bsh;
        endcase
    end

    // flags describe ain - bsh, which is what the alu produces during a compare.
    always_comb begin
        flags.z = (alu_out == '0);
        flags.n = alu_out[word_w-1];
        flags.v = (ain[word_w-1] != bsh[word_w-1]) && (alu_out[word_w-1] != ain[word_w-1]);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            c      <= '0;
            status <= '0;
        end else begin
            if (ctrl.en_c) begin
                c <= alu_out;
            end
            if (ctrl.en_status) begin
                status <= flags;
            end
        end
    end

    always_comb begin
        case (ctrl.wb_sel)
            wb_imm:  wr_data = dec.sximm8;
            default: wr_data = c;
        endcase
    end

    assign out = c;

endmodule

//--- datapath/regfile.sv
module regfile (
    input  logic                           clk,
    input  logic                           w_en,
    input  logic [cpu_pkg::reg_num_w-1:0]  w_num,
    input  logic [cpu_pkg::reg_num_w-1:0]  r_num,
    input  logic [cpu_pkg::word_w-1:0]     wr_data,
    output logic [cpu_pkg::word_w-1:0]     rd_data
);
    import cpu_pkg::*;

    logic [word_w-1:0] regs [reg_cnt];

    always_ff @(posedge clk) begin
        if (w_en) begin
            regs[w_num] <= wr_data;
        end
    end

    assign rd_data = regs[r_num]; // the read port is asynchronous.

endmodule

//--- design/controller.sv
module controller (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  cpu_pkg::decoded_t dec,
    output logic              waiting,
    output cpu_pkg::ctrl_t    ctrl
);
    import cpu_pkg::*;

    typedef enum logic [4:0] {
        st_wait,
        st_mov1,
        st_movr1,
        st_movr2,
        st_movr3,
        st_mvn1,
        st_mvn2,
        st_mvn3,
        st_add1,
        st_add2,
        st_add3,
        st_add4,
        st_cmp1,
        st_cmp2,
        st_cmp3,
        st_cmp4,
        st_and1,
        st_and2,
        st_and3,
        st_and4
    } state_t;

    state_t state;
    state_t state_next;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_wait;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = st_wait;
        case (state)
            st_wait: begin
                if (start && dec.opcode == op_alu) begin
                    case (dec.op)
                        alu_add: state_next = st_add1;
                        alu_cmp: state_next = st_cmp1;
                        alu_and: state_next = st_and1;
                        default: state_next = st_mvn1;
                    endcase
                end else if (start && dec.opcode == op_mov) begin
                    if (dec.op == mov_imm) begin
                        state_next = st_mov1;
                    end else if (dec.op == mov_reg) begin
                        state_next = st_movr1;
                    end
                end
            end
            st_movr1: state_next = st_movr2;
            st_movr2: state_next = st_movr3;
            st_mvn1:  state_next = st_mvn2;
            st_mvn2:  state_next = st_mvn3;
            st_add1:  state_next = st_add2;
            st_add2:  state_next = st_add3;
            st_add3:  state_next = st_add4;
            st_cmp1:  state_next = st_cmp2;
            st_cmp2:  state_next = st_cmp3;
            st_cmp3:  state_next = st_cmp4; // nothing to do here, the flags load next.
            st_and1:  state_next = st_and2;
            st_and2:  state_next = st_and3;
            st_and3:  state_next = st_and4;
            default:  state_next = st_wait;
        endcase
    end

    assign waiting = (state == st_wait);

    always_comb begin
        ctrl = '0;
        case (state)
            st_mov1: begin
                ctrl.nsel   = sel_rn;
                ctrl.wb_sel = wb_imm;
                ctrl.w_en   = 1'b1;
            end
            st_add1, st_cmp1, st_and1: begin
                ctrl.nsel = sel_rn;
                ctrl.en_a = 1'b1;
            end
            st_add2, st_cmp2, st_and2, st_mvn1, st_movr1: begin
                ctrl.nsel = sel_rm;
                ctrl.en_b = 1'b1;
            end
            st_add3, st_and3: begin
                ctrl.en_c = 1'b1;
            end
            st_mvn2, st_movr2: begin
                ctrl.sel_a = 1'b1;
                ctrl.en_c  = 1'b1;
            end
            st_cmp4: begin
                ctrl.en_status = 1'b1;
            end
            st_add4, st_and4, st_mvn3, st_movr3: begin
                ctrl.nsel   = sel_rd;
                ctrl.wb_sel = wb_c;
                ctrl.w_en   = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

//--- design/cpu.sv
module cpu (
    input  logic                        clk,
    input  logic                        rst_n,
    input  logic                        load,
    input  logic                        start,
    input  logic [cpu_pkg::word_w-1:0]  instr,
    output logic                        waiting,
    output logic [cpu_pkg::word_w-1:0]  out,
    output cpu_pkg::status_t            status
);
    import cpu_pkg::*;

    decoded_t             dec;
    ctrl_t                ctrl;
    logic [reg_num_w-1:0] reg_num;
    logic [word_w-1:0]    rd_data;
    logic [word_w-1:0]    wr_data;

    instr_decoder instr_decoder_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (load),
        .instr   (instr),
        .nsel    (ctrl.nsel),
        .dec     (dec),
        .reg_num (reg_num)
    );

    controller controller_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (start),
        .dec     (dec),
        .waiting (waiting),
        .ctrl    (ctrl)
    );

    // the same register number addresses the read and the write port.
    regfile regfile_i (
        .clk     (clk),
        .w_en    (ctrl.w_en),
        .w_num   (reg_num),
        .r_num   (reg_num),
        .wr_data (wr_data),
        .rd_data (rd_data)
    );

    datapath datapath_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .ctrl    (ctrl),
        .dec     (dec),
        .rd_data (rd_data),
        .wr_data (wr_data),
        .out     (out),
        .status  (status)
    );

endmodule

//--- design/instr_decoder.sv
module instr_decoder (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           load,
    input  logic [cpu_pkg::word_w-1:0]     instr,
    input  cpu_pkg::nsel_t                 nsel,
    output cpu_pkg::decoded_t              dec,
    output logic [cpu_pkg::reg_num_w-1:0]  reg_num
);
    import cpu_pkg::*;

    logic [word_w-1:0]    ir;
    logic [reg_num_w-1:0] rn;
    logic [reg_num_w-1:0] rd;
    logic [reg_num_w-1:0] rm;
    logic [7:0]           imm8;

    // the register keeps its contents through reset, but no load lands while reset is held.
    always_ff @(posedge clk) begin
        if (load && rst_n) begin
            ir <= instr;
        end
    end

    assign rn   = ir[10:8];
    assign rd   = ir[7:5];
    assign rm   = ir[2:0];
    assign imm8 = ir[7:0];

    always_comb begin
        dec.opcode = opcode_t'(ir[15:13]);
        dec.op     = alu_op_t'(ir[12:11]);
        dec.shift  = shift_t'(ir[4:3]);
        dec.sximm8 = {{(word_w - 8){imm8[7]}}, imm8};
    end

    // one port number serves both the read and the write side of the register file.
    always_comb begin
        case (nsel)
            sel_rn:  reg_num = rn;
            sel_rd:  reg_num = rd;
            default: reg_num = rm;
        endcase
    end

endmodule

//--- list.f
common/cpu_pkg.sv
design/instr_decoder.sv
design/controller.sv
datapath/regfile.sv
datapath/datapath.sv
design/cpu.sv
verif/tb_cpu.sv

//--- verif/cpu_testdata.txt
// columns: instr_kind_result_flags, one vector per line, all in hex.
// kind 0 setup, 1 result, 2 flags, 3 ignored start; flags hold z, n, v in bits 2:0.
D0FD_0_0000_0 // MOV R0,#-3
C020_1_FFFD_0 // MOV R1,R0
D205_0_0000_0 // MOV R2,#5
D340_0_0000_0 // MOV R3,#0x40
D680_0_0000_0 // MOV R6,#-128
A283_1_0045_0 // ADD R4,R2,R3
A28B_1_0085_0 // ADD R4,R2,R3,LSL
A2B0_1_8003_0 // ADD R5,R2,R0,LSR
A2B8_1_0003_0 // ADD R5,R2,R0,ASR
C0F0_1_7FFE_0 // MOV R7,R0,LSR
AA02_2_0000_4 // CMP R2,R2
AB0A_2_0000_0 // CMP R3,R2,LSL
AA03_2_0000_2 // CMP R2,R3
AF06_2_0000_3 // CMP R7,R6
B726_1_7F80_0 // AND R1,R7,R6
B62C_1_0100_0 // AND R1,R6,R4,LSL
B825_1_FFFC_0 // MVN R1,R5
B83E_1_003F_0 // MVN R1,R6,ASR
00E7_3_0000_0 // opcode 000
C8E0_3_0000_0 // move class with op 01
F0FF_3_0000_0 // opcode 111
C027_1_7FFE_0 // MOV R1,R7
C020_1_FFFD_0 // MOV R1,R0
C04B_1_0080_0 // MOV R2,R3,LSL
B072_1_0040_0 // AND R3,R0,R2,LSR
B888_1_0005_0 // MVN R4,R0,LSL
A6AE_1_FE80_0 // ADD R5,R6,R6,LSL
AE07_2_0000_1 // CMP R6,R7
D07F_0_0000_0 // MOV R0,#0x7f
C020_1_007F_0 // MOV R1,R0

//--- verif/tb_cpu.sv
module tb_cpu;
    import cpu_pkg::*;

    localparam int max_vec  = 64;
    localparam int max_wait = 16;

    localparam logic [3:0] kind_result  = 4'd1;
    localparam logic [3:0] kind_flags   = 4'd2;
    localparam logic [3:0] kind_ignored = 4'd3;

    typedef struct packed {
        logic [15:0] instr;
        logic [3:0]  kind;
        logic [15:0] exp_out;
        logic [3:0]  exp_flags; // z, n and v sit in bits 2:0.
    } vector_t;

    logic              clk;
    logic              rst_n;
    logic              load;
    logic              start;
    logic [word_w-1:0] instr;
    logic              waiting;
    logic [word_w-1:0] out;
    status_t           status;

    logic [39:0]       mem [max_vec];
    vector_t           vec;
    logic [word_w-1:0] prev_out;
    status_t           prev_status;
    logic              loaded;
    int                vec_cnt;
    int                error_cnt;
    int                check_cnt;
    int                cycles;
    int                idx;

    cpu cpu_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (load),
        .start   (start),
        .instr   (instr),
        .waiting (waiting),
        .out     (out),
        .status  (status)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // cycles from the edge that samples start until waiting is high again.
    function automatic int expected_latency(input logic [15:0] word);
        logic [2:0] opc;
        logic [1:0] opf;
        opc = word[15:13];
        opf = word[12:11];
        if (opc == op_mov && opf == mov_imm) begin
            return 2;
        end else if (opc == op_mov && opf == mov_reg) begin
            return 4;
        end else if (opc == op_alu && opf == alu_mvn) begin
            return 4;
        end else if (opc == op_alu) begin
            return 5;
        end
        return 1; // an ignored start never leaves the idle state.
    endfunction

    task automatic load_instr(input logic [word_w-1:0] word);
        instr = word;
        load  = 1'b1;
        @(negedge clk);
        load  = 1'b0;
    endtask

    task automatic run_instr(output int n);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        n = 1;
        while (!waiting && n < max_wait) begin
            @(negedge clk);
            n++;
        end
    endtask

    initial begin
        loaded = 1'b0;
        wait (loaded);
        #((vec_cnt * 8 + 10) * 100);
        $display("timeout: the run did not end within %0d clock cycles", vec_cnt * 8 + 10);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        rst_n     = 1'b0;
        load      = 1'b0;
        start     = 1'b0;
        instr     = '0;
        error_cnt = 0;
        check_cnt = 0;
        vec_cnt   = 0;
        for (idx = 0; idx < max_vec; idx++) begin
            mem[idx] = '1;
        end
        $readmemh("verif/cpu_testdata.txt", mem);
        for (idx = 0; idx < max_vec; idx++) begin
            vec = mem[idx];
            if (vec.kind != 4'hf && vec_cnt == idx) begin
                vec_cnt++;
            end
        end
        loaded = 1'b1;

        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        check_cnt++;
        if (!waiting || out !== '0 || status !== '0) begin
            $display("ERROR %0t: after reset waiting=%b out=%h status=%b", $time,
                     waiting, out, status);
            error_cnt++;
        end
        if (vec_cnt == 0) begin
            $display("no vectors were read from verif/cpu_testdata.txt");
            error_cnt++;
        end

        for (idx = 0; idx < vec_cnt; idx++) begin
            vec         = mem[idx];
            prev_out    = out;
            prev_status = status;
            load_instr(vec.instr);
            run_instr(cycles);

            check_cnt++;
            if (!waiting) begin
                $display("vector %0d: waiting did not return high within %0d cycles",
                         idx, max_wait);
                error_cnt++;
            end else if (cycles != expected_latency(vec.instr)) begin
                $display("ERROR %0t: vector %0d took %0d cycles, expected %0d", $time,
                         idx, cycles, expected_latency(vec.instr));
                error_cnt++;
            end
            if (vec.kind > kind_ignored) begin
                $display("vector %0d has check kind %0d, which is not defined", idx, vec.kind);
                error_cnt++;
            end

            check_cnt++;
            if (vec.kind == kind_result) begin
                if (out !== vec.exp_out) begin
                    $display("ERROR %0t: vector %0d out=%h, expected %h", $time,
                             idx, out, vec.exp_out);
                    error_cnt++;
                end
            end else if (out !== prev_out) begin
                $display("ERROR %0t: vector %0d out changed from %h to %h", $time,
                         idx, prev_out, out);
                error_cnt++;
            end

            check_cnt++;
            if (vec.kind == kind_flags) begin
                if (status !== vec.exp_flags[2:0]) begin
                    $display("ERROR %0t: vector %0d flags znv=%b, expected %b", $time,
                             idx, status, vec.exp_flags[2:0]);
                    error_cnt++;
                end
            end else if (status !== prev_status) begin
                $display("ERROR %0t: vector %0d flags changed from %b to %b", $time,
                         idx, prev_status, status);
                error_cnt++;
            end
        end

        $display("%0d vectors, %0d checks, %0d errors", vec_cnt, check_cnt, error_cnt);
        if (error_cnt == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
